//--- logic/membridge_pkg.sv
////////////////////
// membridge shared definitions
// register map, widths, register word decode and burst descriptor
////////////////////
`default_nettype none

package membridge_pkg;

    localparam int ADDR64_W      = 29;  // word address, byte addr >> 3
    localparam int DATA_W        = 64;  // buffer and axi data word
    localparam int REG_A_W       = 4;   // register address bits
    localparam int BURST_MAX     = 16;  // longest axi burst in words
    localparam int LEN_W         = 5;   // burst length, must hold 16
    localparam int BURST_Q_DEPTH = 4;   // bursts waiting for data beats
    localparam int Q_PTR_W       = $clog2(BURST_Q_DEPTH);
    localparam int Q_CNT_W       = Q_PTR_W + 1;  // 0..depth
    localparam int RESP_CNT_W    = 8;   // bursts waiting for bresp

    // register map
    localparam logic [REG_A_W-1:0] REG_CTRL      = REG_A_W'(0); // enable, start, keep_addr
    localparam logic [REG_A_W-1:0] REG_LO_ADDR64 = REG_A_W'(2); // window base, words
    localparam logic [REG_A_W-1:0] REG_SIZE64    = REG_A_W'(3); // window size, words
    localparam logic [REG_A_W-1:0] REG_START64   = REG_A_W'(4); // start, relative to base
    localparam logic [REG_A_W-1:0] REG_LEN64     = REG_A_W'(5); // transfer length, words

    // control word layout
    typedef struct packed {
        logic [28:0] rsvd;
        logic        keep_addr;  // continue from last rel address
        logic        start;      // kick a transfer
        logic        enable;     // bridge on, clearing drops done
    } ctrl_t;

    // address / length layout
    typedef struct packed {
        logic [31-ADDR64_W:0] rsvd;
        logic [ADDR64_W-1:0]  addr64;
    } addr_fld_t;

    // one write word, two views picked by register address
    typedef union packed {
        ctrl_t     ctrl;
        addr_fld_t fld;
    } reg_data_u;

    typedef struct packed {
        logic [REG_A_W-1:0] addr;
        reg_data_u          data;
    } reg_wr_t;

    // transfer setup, regs -> planner
    typedef struct packed {
        logic [ADDR64_W-1:0] lo_addr64;
        logic [ADDR64_W-1:0] size64;
        logic [ADDR64_W-1:0] start64;
        logic [ADDR64_W-1:0] len64;
        logic                keep_addr;
    } xfer_cfg_t;

    // one write burst
    typedef struct packed {
        logic [ADDR64_W-1:0] addr64;  // absolute word address
        logic [LEN_W-1:0]    len;     // 1..BURST_MAX words
    } burst_t;

endpackage

`default_nettype wire

//--- logic/bridge_regs.sv
////////////////////
// bridge_regs
// host register file behind a four-phase req/ack write port,
// start pulse generation and busy / done status
////////////////////
`default_nettype none

module bridge_regs import membridge_pkg::*; (
    input  logic      hclk,
    input  logic      rst,
    input  reg_wr_t   reg_wr_i,     // held stable while req is high
    input  logic      reg_req_i,
    output logic      reg_ack_o,
    input  logic      xfer_idle_i,  // all bursts answered
    input  logic      plan_done_i,  // planner has issued everything
    output xfer_cfg_t cfg_o,
    output logic      start_o,      // one cycle kick to the planner
    output logic      busy_o,
    output logic      done_o
);

    logic                wr_stb;      // first cycle of a host write
    reg_data_u           wd;
    logic [ADDR64_W-1:0] aligned64;   // address field on a 16 word grid
    logic                set_ctrl;
    logic                set_lo;
    logic                set_size;
    logic                set_start;
    logic                set_len;
    logic                enable;

    assign wr_stb    = reg_req_i && !reg_ack_o;  // ack still low
    assign wd        = reg_wr_i.data;
    assign aligned64 = {wd.fld.addr64[ADDR64_W-1:4], 4'b0000};

    assign set_ctrl  = wr_stb && (reg_wr_i.addr == REG_CTRL);
    assign set_lo    = wr_stb && (reg_wr_i.addr == REG_LO_ADDR64);
    assign set_size  = wr_stb && (reg_wr_i.addr == REG_SIZE64);
    assign set_start = wr_stb && (reg_wr_i.addr == REG_START64);
    assign set_len   = wr_stb && (reg_wr_i.addr == REG_LEN64);

    // ack mirrors req one cycle late
    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            reg_ack_o <= 1'b0;
        end else begin
            reg_ack_o <= reg_req_i;
        end
    end

    // setup registers
    always_ff @(posedge hclk) begin
        if (set_lo)    cfg_o.lo_addr64 <= aligned64;
        if (set_size)  cfg_o.size64    <= aligned64;
        if (set_lo)
            cfg_o.start64 <= '0;         // new window restarts at base
        else if (set_start)
            cfg_o.start64 <= aligned64;
        if (set_len)   cfg_o.len64     <= wd.fld.addr64;  // any length
        if (set_ctrl)  cfg_o.keep_addr <= wd.ctrl.keep_addr;
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            enable  <= 1'b0;
            start_o <= 1'b0;
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            if (set_ctrl) enable <= wd.ctrl.enable;
            // start only from an idle and enabled bridge
            start_o <= set_ctrl && wd.ctrl.start && wd.ctrl.enable && !busy_o;
            if (start_o)
                busy_o <= 1'b1;
            else if (xfer_idle_i && plan_done_i)
                busy_o <= 1'b0;          // last bresp seen
            if (!enable || start_o)
                done_o <= 1'b0;
            else if (busy_o && xfer_idle_i && plan_done_i)
                done_o <= 1'b1;          // same edge busy drops
        end
    end

    // host keeps req and the write word up until acked
    a_req_held: assert property (@(posedge hclk) disable iff (rst)
        reg_req_i && !reg_ack_o |=> reg_req_i && $stable(reg_wr_i));

endmodule

`default_nettype wire

//--- logic/burst_planner.sv
////////////////////
// burst_planner
// walks relative address and words left, cuts the run into
// bursts of up to 16 words with rollover inside the window
////////////////////
`default_nettype none

module burst_planner import membridge_pkg::*; (
    input  logic      hclk,
    input  logic      rst,
    input  xfer_cfg_t cfg_i,
    input  logic      start_i,
    output burst_t    burst_o,
    output logic      burst_valid_o,
    input  logic      burst_ready_i,
    output logic      plan_done_o     // all bursts handed over
);

    logic [ADDR64_W-1:0] rel;         // address relative to lo_addr64
    logic [ADDR64_W-1:0] left;        // words still to plan
    logic [ADDR64_W-1:4] last_blk;    // last 16 word block of window
    logic                last_burst;  // registered, left fits one burst
    logic                rollover;    // registered, rel at window end
    logic                calc;        // rel / left just changed
    logic                hs;
    logic [ADDR64_W-1:0] addr_r;      // registered lo + rel
    logic [LEN_W-1:0]    len_r;

    assign hs       = burst_valid_o && burst_ready_i;
    assign last_blk = cfg_i.size64[ADDR64_W-1:4] - 1'b1;
    assign burst_o  = '{addr64: addr_r, len: len_r};

    // control
    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            calc          <= 1'b0;
            burst_valid_o <= 1'b0;
            plan_done_o   <= 1'b0;
        end else if (start_i) begin
            calc          <= 1'b1;       // load first, then add
            burst_valid_o <= 1'b0;
            plan_done_o   <= 1'b0;
        end else if (hs) begin
            burst_valid_o <= 1'b0;
            calc          <= !last_burst;
            plan_done_o   <= last_burst;
        end else if (calc) begin
            calc          <= 1'b0;
            burst_valid_o <= (left != '0);
            plan_done_o   <= (left == '0);  // zero length transfer
        end
    end

    // address and length walk
    always_ff @(posedge hclk) begin
        if (start_i) begin
            if (!cfg_i.keep_addr)
                rel <= cfg_i.start64;
            left <= cfg_i.len64;
        end else if (hs) begin
            // whole block step, wrap after the top block
            rel  <= rollover ? '0 : rel + ADDR64_W'(BURST_MAX);
            left <= last_burst ? '0 : left - ADDR64_W'(BURST_MAX);
        end

        if (calc) begin
            addr_r     <= cfg_i.lo_addr64 + rel;
            len_r      <= (|left[ADDR64_W-1:4]) ? LEN_W'(BURST_MAX) : LEN_W'(left[3:0]);
            last_burst <= (left <= ADDR64_W'(BURST_MAX));
            rollover   <= (rel[ADDR64_W-1:4] == last_blk);
        end
    end

    a_burst_len: assert property (@(posedge hclk) disable iff (rst)
        burst_valid_o |-> (burst_o.len != '0) && (burst_o.len <= LEN_W'(BURST_MAX)));

endmodule

`default_nettype wire

//--- logic/axi_wr_master.sv
////////////////////
// axi_wr_master
// axi write address and data channels, buffer word intake,
// burst length queue and bresp counting
////////////////////
`default_nettype none

module axi_wr_master import membridge_pkg::*; (
    input  logic              hclk,
    input  logic              rst,
    input  burst_t            burst_i,
    input  logic              burst_valid_i,
    output logic              burst_ready_o,
    input  logic [DATA_W-1:0] word_i,
    input  logic              word_req_i,
    output logic              word_ack_o,
    output logic [31:0]       aw_addr_o,    // byte address
    output logic [3:0]        aw_len_o,     // beats - 1
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output logic [DATA_W-1:0] w_data_o,
    output logic              w_last_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    output logic              xfer_idle_o   // no burst waiting for bresp
);

    logic [ADDR64_W-1:0]   aw_addr64;
    logic [LEN_W-1:0]      len_m1;
    logic                  take_burst;
    logic                  q_full;
    logic [LEN_W-1:0]      q_len [BURST_Q_DEPTH];  // lengths waiting for data
    logic [Q_PTR_W-1:0]    wr_ptr;
    logic [Q_PTR_W-1:0]    rd_ptr;
    logic [Q_CNT_W-1:0]    q_cnt;
    logic [LEN_W-1:0]      beat_cnt;    // beats sent in head burst
    logic [LEN_W-1:0]      beat_nxt;
    logic                  last_beat;
    logic                  beat_free;   // output beat empty next edge
    logic                  take_word;
    logic                  pop;
    logic                  b_hs;
    logic [RESP_CNT_W-1:0] resp_cnt;

    assign q_full        = (q_cnt == Q_CNT_W'(BURST_Q_DEPTH));
    assign burst_ready_o = (!aw_valid_o || aw_ready_i) && !q_full;
    assign take_burst    = burst_valid_i && burst_ready_o;
    assign len_m1        = burst_i.len - 1'b1;
    assign aw_addr_o     = {aw_addr64, 3'b000};

    // address channel
    always_ff @(posedge hclk or posedge rst) begin
        if (rst)             aw_valid_o <= 1'b0;
        else if (take_burst) aw_valid_o <= 1'b1;
        else if (aw_ready_i) aw_valid_o <= 1'b0;
    end

    always_ff @(posedge hclk) begin
        if (take_burst) begin
            aw_addr64     <= burst_i.addr64;
            aw_len_o      <= len_m1[LEN_W-2:0];
            q_len[wr_ptr] <= burst_i.len;
        end
        if (take_word) w_data_o <= word_i;
    end

    // data side
    assign beat_free = !w_valid_o || w_ready_i;
    assign take_word = word_req_i && !word_ack_o && (q_cnt != '0) && beat_free;
    assign beat_nxt  = beat_cnt + 1'b1;
    assign last_beat = (beat_nxt == q_len[rd_ptr]);
    assign pop       = take_word && last_beat;  // head burst fully sent

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
            beat_cnt   <= '0;
            word_ack_o <= 1'b0;
            w_valid_o  <= 1'b0;
            w_last_o   <= 1'b0;
        end else begin
            if (take_burst) wr_ptr <= wr_ptr + 1'b1;
            if (pop)        rd_ptr <= rd_ptr + 1'b1;
            case ({take_burst, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            if (take_word) beat_cnt <= last_beat ? '0 : beat_nxt;
            // four-phase ack drops a cycle after req
            word_ack_o <= take_word || (word_ack_o && word_req_i);
            w_valid_o  <= take_word || (w_valid_o && !w_ready_i);
            w_last_o   <= take_word ? last_beat : (w_last_o && !w_ready_i);
        end
    end

    // response side
    assign b_ready_o   = 1'b1;
    assign b_hs        = b_valid_i && b_ready_o;
    assign xfer_idle_o = (resp_cnt == '0);

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            resp_cnt <= '0;
        end else begin
            case ({take_burst, b_hs})
                2'b10:   resp_cnt <= resp_cnt + 1'b1;  // planned but not answered
                2'b01:   resp_cnt <= resp_cnt - 1'b1;
                default: resp_cnt <= resp_cnt;
            endcase
        end
    end

    // descriptor source holds its offer until taken
    a_burst_held: assert property (@(posedge hclk) disable iff (rst)
        burst_valid_i && !burst_ready_o |=> burst_valid_i && $stable(burst_i));
    // buffer word stays put until acked
    a_word_held: assert property (@(posedge hclk) disable iff (rst)
        word_req_i && !word_ack_o |=> word_req_i && $stable(word_i));

endmodule

`default_nettype wire

//--- logic/membridge_top.sv
////////////////////
// membridge_top
// buffer to system memory write bridge, regs -> planner -> axi master
////////////////////
`default_nettype none

module membridge_top import membridge_pkg::*; (
    input  logic              hclk,
    input  logic              rst,
    // host register port
    input  reg_wr_t           reg_wr_i,
    input  logic              reg_req_i,
    output logic              reg_ack_o,
    // buffer word source
    input  logic [DATA_W-1:0] word_i,
    input  logic              word_req_i,
    output logic              word_ack_o,
    // axi write
    output logic [31:0]       aw_addr_o,
    output logic [3:0]        aw_len_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output logic [DATA_W-1:0] w_data_o,
    output logic              w_last_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    // status
    output logic              busy_o,
    output logic              done_o
);

    xfer_cfg_t cfg;
    logic      start;
    burst_t    burst;
    logic      burst_valid;
    logic      burst_ready;
    logic      plan_done;
    logic      xfer_idle;

    bridge_regs regs_i (
        .hclk        (hclk),
        .rst         (rst),
        .reg_wr_i    (reg_wr_i),
        .reg_req_i   (reg_req_i),
        .reg_ack_o   (reg_ack_o),
        .xfer_idle_i (xfer_idle),
        .plan_done_i (plan_done),
        .cfg_o       (cfg),
        .start_o     (start),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    burst_planner planner_i (
        .hclk          (hclk),
        .rst           (rst),
        .cfg_i         (cfg),
        .start_i       (start),
        .burst_o       (burst),
        .burst_valid_o (burst_valid),
        .burst_ready_i (burst_ready),
        .plan_done_o   (plan_done)
    );

    axi_wr_master master_i (
        .hclk          (hclk),
        .rst           (rst),
        .burst_i       (burst),
        .burst_valid_i (burst_valid),
        .burst_ready_o (burst_ready),
        .word_i        (word_i),
        .word_req_i    (word_req_i),
        .word_ack_o    (word_ack_o),
        .aw_addr_o     (aw_addr_o),
        .aw_len_o      (aw_len_o),
        .aw_valid_o    (aw_valid_o),
        .aw_ready_i    (aw_ready_i),
        .w_data_o      (w_data_o),
        .w_last_o      (w_last_o),
        .w_valid_o     (w_valid_o),
        .w_ready_i     (w_ready_i),
        .b_valid_i     (b_valid_i),
        .b_ready_o     (b_ready_o),
        .xfer_idle_o   (xfer_idle)
    );

endmodule

`default_nettype wire

//--- verification/tb_mem_slave.sv
////////////////////
// tb_mem_slave
// axi write slave model with lfsr driven ready signals,
// handshake capture and write responses
////////////////////
`default_nettype none

module tb_mem_slave (
    input  logic hclk,
    input  logic rst,
    input  logic rnd_i,        // random ready when set, else always ready
    input  logic aw_valid_i,
    output logic aw_ready_o,
    input  logic w_valid_i,
    input  logic w_last_i,
    output logic w_ready_o,
    output logic b_valid_o,
    input  logic b_ready_i,
    output int   aw_seen_o,    // address handshakes so far
    output int   w_seen_o      // data beats so far
);

    logic [31:0] lfsr;
    logic [31:0] lfsr_a;       // one step on, aw_ready bit
    logic [31:0] lfsr_b;       // two steps on, w_ready bit
    logic        aw_hs;
    logic        w_hs;
    logic        b_hs;
    int          aw_pend;      // addresses not yet answered
    int          wl_pend;      // last beats not yet answered
    int          aw_left;
    int          wl_left;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign lfsr_a  = lfsr_step(lfsr);
    assign lfsr_b  = lfsr_step(lfsr_a);
    assign aw_hs   = aw_valid_i && aw_ready_o;
    assign w_hs    = w_valid_i && w_ready_o;
    assign b_hs    = b_valid_o && b_ready_i;
    assign aw_left = aw_pend - int'(b_hs);
    assign wl_left = wl_pend - int'(b_hs);

    always @(posedge hclk or posedge rst) begin
        if (rst) begin
            lfsr       <= 32'h4e00;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
        end else if (rnd_i) begin
            aw_ready_o <= lfsr_a[0];   // newest bit of each step
            w_ready_o  <= lfsr_b[0];
            lfsr       <= lfsr_b;
        end else begin
            aw_ready_o <= 1'b1;
            w_ready_o  <= 1'b1;
        end
    end

    // capture counts, one bresp per address plus last beat
    always @(posedge hclk or posedge rst) begin
        if (rst) begin
            aw_seen_o <= 0;
            w_seen_o  <= 0;
            aw_pend   <= 0;
            wl_pend   <= 0;
            b_valid_o <= 1'b0;
        end else begin
            aw_seen_o <= aw_seen_o + int'(aw_hs);
            w_seen_o  <= w_seen_o + int'(w_hs);
            aw_pend   <= aw_left + int'(aw_hs);
            wl_pend   <= wl_left + int'(w_hs && w_last_i);
            b_valid_o <= (aw_left > 0) && (wl_left > 0);
        end
    end

endmodule

`default_nettype wire

//--- verification/membridge_tb.sv
////////////////////
// membridge testbench
// programs the bridge, checks bursts and beats against the address rule
////////////////////
`default_nettype none

module membridge_tb import membridge_pkg::*; ();

    localparam int TMO = 2000;  // cycles per wait

    logic              hclk;
    logic              rst;
    reg_wr_t           reg_wr_i;
    logic              reg_req_i;
    logic              reg_ack_o;
    logic [DATA_W-1:0] word_i = '0;
    logic              word_req_i = 1'b0;
    logic              word_ack_o;
    logic [31:0]       aw_addr_o;
    logic [3:0]        aw_len_o;
    logic              aw_valid_o, aw_ready_i;
    logic [DATA_W-1:0] w_data_o;
    logic              w_last_o, w_valid_o, w_ready_i;
    logic              b_valid_i, b_ready_o;
    logic              busy_o, done_o;
    logic              rnd;             // random ready on the slave
    int                aw_seen;
    int                w_seen;
    int                word_cnt = 0;    // words acked by the dut
    logic [31:0]       exp_addr [64];   // per burst, whole run
    int                exp_len [64];
    logic              exp_last [512];  // per beat, whole run
    int                exp_n = 0;
    int                exp_beats = 0;
    int                m_lo, m_size, m_start, m_len;  // register shadow
    int                m_rel = 0;       // rel after the last transfer
    int                errors = 0;
    int                err_mark = 0;
    int                test_n = 0;
    int                fails = 0;

    always #5 hclk = ~hclk;

    membridge_top dut0 (.*);

    tb_mem_slave mem0 (
        .hclk       (hclk),
        .rst        (rst),
        .rnd_i      (rnd),
        .aw_valid_i (aw_valid_o),
        .aw_ready_o (aw_ready_i),
        .w_valid_i  (w_valid_o),
        .w_last_i   (w_last_o),
        .w_ready_o  (w_ready_i),
        .b_valid_o  (b_valid_i),
        .b_ready_i  (b_ready_o),
        .aw_seen_o  (aw_seen),
        .w_seen_o   (w_seen)
    );

    // four-phase word source, data 1, 2, 3 ...
    always @(posedge hclk) begin
        if (!word_req_i && !word_ack_o) begin
            word_i     <= DATA_W'(word_cnt + 1);
            word_req_i <= 1'b1;
        end else if (word_req_i && word_ack_o) begin
            word_req_i <= 1'b0;
            word_cnt   <= word_cnt + 1;
        end
    end

    a_aw_addr: assert property (@(posedge hclk) disable iff (rst)
        aw_valid_o && aw_ready_i |-> aw_addr_o == exp_addr[aw_seen])
        else report_mismatch("aw_addr_o", $sampled(aw_addr_o), exp_addr[$sampled(aw_seen)]);
    a_aw_len: assert property (@(posedge hclk) disable iff (rst)
        aw_valid_o && aw_ready_i |-> aw_len_o == 4'(exp_len[aw_seen] - 1))
        else report_mismatch("aw_len_o", $sampled(aw_len_o), exp_len[$sampled(aw_seen)] - 1);
    a_w_data: assert property (@(posedge hclk) disable iff (rst)
        w_valid_o && w_ready_i |-> w_data_o == DATA_W'(w_seen + 1))
        else report_mismatch("w_data_o", $sampled(w_data_o), $sampled(w_seen) + 1);
    a_w_last: assert property (@(posedge hclk) disable iff (rst)
        w_valid_o && w_ready_i |-> w_last_o == exp_last[w_seen])
        else report_mismatch("w_last_o", $sampled(w_last_o), exp_last[$sampled(w_seen)]);
    a_done_idle: assert property (@(posedge hclk) disable iff (rst) done_o |-> !busy_o)
        else begin
            errors++;
            $display("done_o and busy_o both high at %0t", $time);
        end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expv);
        errors++;
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, expv);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expv);
        assert (got === expv) else report_mismatch(name, got, expv);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (reg_ack_o !== level && n < TMO) begin
            @(posedge hclk);
            n++;
        end
        if (reg_ack_o !== level) begin
            errors++;
            $display("reg_ack_o stuck at %0b for %0d cycles at %0t", !level, TMO, $time);
        end
    endtask

    task automatic write_reg(input logic [REG_A_W-1:0] a, input logic [31:0] d);
        @(posedge hclk);
        reg_wr_i.addr <= a;
        reg_wr_i.data <= d;
        reg_req_i     <= 1'b1;
        wait_ack(1'b1);
        reg_req_i     <= 1'b0;      // dropped even after a timeout
        wait_ack(1'b0);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o && n < TMO) begin
            @(posedge hclk);
            n++;
        end
        if (!done_o) begin
            errors++;
            $display("done_o did not rise within %0d cycles at %0t", TMO, $time);
        end
    endtask

    task automatic set_window(input int lo, input int size, input int start, input int len);
        write_reg(REG_LO_ADDR64, 32'(lo));
        write_reg(REG_SIZE64, 32'(size));
        write_reg(REG_START64, 32'(start));
        write_reg(REG_LEN64, 32'(len));
        m_lo    = lo & ~15;         // 16 word grid
        m_size  = size & ~15;
        m_start = start & ~15;
        m_len   = len;
    endtask

    // bursts and beats that the next transfer must produce
    task automatic expect_bursts(input logic keep);
        int rel;
        int left;
        int blen;
        int b;
        rel  = keep ? m_rel : m_start;
        left = m_len;
        while (left > 0) begin
            blen            = (left > BURST_MAX) ? BURST_MAX : left;
            exp_addr[exp_n] = 32'((m_lo + rel) * 8);  // byte address
            exp_len[exp_n]  = blen;
            exp_n++;
            for (b = 0; b < blen; b++) begin
                exp_last[exp_beats] = (b == blen - 1);
                exp_beats++;
            end
            // back to 0 after the top block of the window
            rel  = (rel / BURST_MAX == m_size / BURST_MAX - 1) ? 0 : rel + BURST_MAX;
            left = left - blen;
        end
        m_rel = rel;
    endtask

    task automatic run_xfer(input logic keep);
        ctrl_t c;
        c           = '0;
        c.enable    = 1'b1;
        c.start     = 1'b1;
        c.keep_addr = keep;
        expect_bursts(keep);
        write_reg(REG_CTRL, c);
        wait_done();
    endtask

    task automatic end_test(input string name);
        check_value("aw handshakes", aw_seen, exp_n);
        check_value("w beats", w_seen, exp_beats);
        test_n++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", test_n, name);
        end else begin
            fails++;
            $display("test %0d %s: %0d errors", test_n, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        ctrl_t c;
        hclk      = 1'b0;
        rst       = 1'b1;
        reg_wr_i  = '0;
        reg_req_i = 1'b0;
        rnd       = 1'b0;
        repeat (3) @(posedge hclk);
        rst <= 1'b0;
        @(posedge hclk);
        check_value("aw_valid_o", aw_valid_o, 0);
        check_value("w_valid_o", w_valid_o, 0);
        check_value("busy_o", busy_o, 0);
        check_value("done_o", done_o, 0);
        check_value("reg_ack_o", reg_ack_o, 0);
        write_reg(REG_LEN64, 32'd0);
        end_test("reset state and register handshake");
        set_window(32'h100, 32'h200, 32'h20, 40);
        run_xfer(1'b0);
        end_test("three bursts");
        set_window(32'h100, 32'h40, 32'h30, 40);
        run_xfer(1'b0);
        end_test("window rollover");
        rnd <= 1'b1;                // stays on from here
        set_window(32'h100, 32'h200, 32'h20, 40);
        run_xfer(1'b0);
        end_test("random ready");
        write_reg(REG_LEN64, 32'd8);
        m_len = 8;
        run_xfer(1'b1);             // continues after the last burst
        end_test("keep address");
        c = '0;
        write_reg(REG_CTRL, c);     // enable off
        check_value("done_o", done_o, 0);
        c.start = 1'b1;
        write_reg(REG_CTRL, c);     // start without enable
        repeat (20) @(posedge hclk);
        check_value("busy_o", busy_o, 0);
        write_reg(REG_LEN64, 32'd0);
        m_len = 0;
        run_xfer(1'b0);
        end_test("enable off and zero length");
        $display("%0d tests, %0d failed, %0d errors", test_n, fails, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/membridge_pkg.sv
logic/bridge_regs.sv
logic/burst_planner.sv
logic/axi_wr_master.sv
logic/membridge_top.sv
verification/tb_mem_slave.sv
verification/membridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= membridge_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
